// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // ModRM byte, msb first
    typedef struct packed {
        logic [1:0] mod;        // 11 selects a register operand
        logic [2:0] regIdx;     // Register operand
        logic [2:0] rm;         // Base mode or second register
    } modRmT;

    // One register, read as a word or as two byte lanes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } regWordU;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        aluAdd, aluOr, aluAdc, aluSbb, aluAnd, aluSub, aluXor, aluCmp
    } aluOpT;

    typedef struct packed {
        logic cf;
        logic zf;
        logic sf;
        logic of;
    } flagsT;

    typedef struct packed {
        logic [2:0] index;      // AX..DI, or AL..BH in byte mode
        logic       isWord;
    } regSelT;

    localparam logic [15:0] resetIp = 16'h0000;
    localparam logic [7:0]  opHlt   = 8'hF4;

    // Base registers for address arithmetic
    localparam logic [2:0] idxBx = 3'd3;
    localparam logic [2:0] idxBp = 3'd5;
    localparam logic [2:0] idxSi = 3'd6;
    localparam logic [2:0] idxDi = 3'd7;

endpackage

`default_nettype wire

// ==== design/busPkg.sv ====
`default_nettype none

package busPkg;

    localparam int addrW = 16;
    localparam int dataW = 8;

    // Core side, one byte per request
    typedef struct packed {
        logic             valid;    // Held until done
        logic             write;
        logic [addrW-1:0] addr;
        logic [dataW-1:0] wdata;
    } memReqT;

    typedef struct packed {
        logic             done;     // Single cycle pulse
        logic [dataW-1:0] rdata;    // Valid with done
    } memRspT;

    // APB side
    typedef struct packed {
        logic             psel;
        logic             penable;
        logic             pwrite;
        logic [addrW-1:0] paddr;
        logic [dataW-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic             pready;
        logic [dataW-1:0] prdata;
    } apbRspT;

endpackage

`default_nettype wire

// ==== design/regFile.sv ====
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  wire logic        clk25,
    input  wire logic        arstN,
    input  wire regSelT      rdSelA,    // ModRM reg
    input  wire regSelT      rdSelB,    // ModRM rm
    output logic      [15:0] rdA,
    output logic      [15:0] rdB,
    input  wire logic        wrEn,
    input  wire regSelT      wrSel,
    input  wire logic [15:0] wrData
);

    regWordU regs [8];  // AX CX DX BX SP BP SI DI

    // Byte index 4..7 maps onto the high half of 0..3
    function automatic logic [15:0] readPort(regSelT sel);
        regWordU r;
        if (sel.isWord) begin
            return regs[sel.index].word;
        end
        r = regs[{1'b0, sel.index[1:0]}];
        return {8'h00, sel.index[2] ? r.bytes.hi : r.bytes.lo};  // Zero extended
    endfunction

    always_comb rdA = readPort(rdSelA);
    always_comb rdB = readPort(rdSelB);

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            if (wrSel.isWord) begin
                regs[wrSel.index].word <= wrData;
            end else if (wrSel.index[2]) begin
                regs[{1'b0, wrSel.index[1:0]}].bytes.hi <= wrData[7:0];   // AH..BH
            end else begin
                regs[{1'b0, wrSel.index[1:0]}].bytes.lo <= wrData[7:0];   // AL..BL
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/eaCalc.sv ====
`default_nettype none

module eaCalc
    import cpuPkg::*;
(
    input  wire modRmT       modRm,
    input  wire logic [15:0] bx,
    input  wire logic [15:0] bp,
    input  wire logic [15:0] si,
    input  wire logic [15:0] di,
    input  wire logic [15:0] disp,     // Already sign extended
    output logic      [15:0] ea
);

    logic [15:0] base;

    // 16-bit addressing modes
    always_comb begin
        case (modRm.rm)
            3'd0: base = bx + si;
            3'd1: base = bx + di;
            3'd2: base = bp + si;
            3'd3: base = bp + di;
            3'd4: base = si;
            3'd5: base = di;
            3'd6: base = (modRm.mod == 2'b00) ? 16'h0000 : bp;  // Direct address
            3'd7: base = bx;
        endcase
        ea = base + disp;
    end

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`default_nettype none

module aluUnit
    import cpuPkg::*;
(
    input  wire aluOpT       op,
    input  wire logic        isWord,
    input  wire logic [15:0] a,        // Destination
    input  wire logic [15:0] b,        // Source
    input  wire logic        cfIn,
    output logic      [15:0] result,
    output flagsT            flagsOut
);

    logic        isSub;
    logic        isLogic;
    logic        carryIn;
    logic [16:0] opA;
    logic [16:0] opB;
    logic [16:0] sum;
    logic [15:0] logicRes;
    logic        msbA;
    logic        msbB;
    logic        msbR;

    always_comb begin
        isSub   = op inside {aluSbb, aluSub, aluCmp};
        isLogic = op inside {aluOr, aluAnd, aluXor};
        carryIn = (op == aluAdc || op == aluSbb) ? cfIn : 1'b0;

        // Zero extended to the operation width, carry lands in bit 8 or 16
        opA = isWord ? {1'b0, a} : {9'h000, a[7:0]};
        opB = isWord ? {1'b0, b} : {9'h000, b[7:0]};
        sum = isSub ? opA - opB - carryIn : opA + opB + carryIn;  // Borrow shows as carry

        case (op)
            aluOr:   logicRes = a | b;
            aluAnd:  logicRes = a & b;
            aluXor:  logicRes = a ^ b;
            default: logicRes = '0;
        endcase

        result = isLogic ? logicRes : sum[15:0];
        if (!isWord) begin
            result[15:8] = 8'h00;
        end

        // Sign bits at width
        msbA = isWord ? a[15] : a[7];
        msbB = isWord ? b[15] : b[7];
        msbR = isWord ? result[15] : result[7];

        flagsOut.cf = !isLogic && (isWord ? sum[16] : sum[8]);
        flagsOut.zf = (result == 16'h0000);
        flagsOut.sf = msbR;
        if (isLogic) begin
            flagsOut.of = 1'b0;
        end else if (isSub) begin
            flagsOut.of = (msbA != msbB) && (msbR != msbA);   // Unlike signs, sign flipped
        end else begin
            flagsOut.of = (msbA == msbB) && (msbR != msbA);
        end
    end

endmodule

`default_nettype wire

// ==== design/apbMaster.sv ====
`default_nettype none

module apbMaster
    import busPkg::*;
(
    input  wire logic   clk25,
    input  wire logic   arstN,
    input  wire memReqT memReq,
    output memRspT      memRsp,
    output apbReqT      apbReq,
    input  wire apbRspT apbRsp
);

    typedef enum logic [1:0] {stIdle, stSetup, stAccess} apbStateT;

    apbStateT         state;
    logic             startXfer;
    logic             doneQ;
    logic             writeQ;
    logic [addrW-1:0] addrQ;
    logic [dataW-1:0] wdataQ;
    logic [dataW-1:0] rdataQ;

    // Request still held high during the done cycle, skip it
    assign startXfer = (state == stIdle) && memReq.valid && !doneQ;

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            doneQ <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            case (state)
                stIdle:   if (startXfer) state <= stSetup;
                stSetup:  state <= stAccess;
                stAccess: if (apbRsp.pready) begin   // Wait states end here
                    state <= stIdle;
                    doneQ <= 1'b1;
                end
                default:  state <= stIdle;
            endcase
        end
    end

    // Address and data held for the whole transfer
    always_ff @(posedge clk25) begin
        if (startXfer) begin
            writeQ <= memReq.write;
            addrQ  <= memReq.addr;
            wdataQ <= memReq.wdata;
        end
        if (state == stAccess && apbRsp.pready) begin
            rdataQ <= apbRsp.prdata;
        end
    end

    always_comb begin
        apbReq.psel    = (state != stIdle);
        apbReq.penable = (state == stAccess);
        apbReq.pwrite  = writeQ;
        apbReq.paddr   = addrQ;
        apbReq.pwdata  = wdataQ;
        memRsp.done    = doneQ;
        memRsp.rdata   = rdataQ;
    end

    // ---------------------------------------------------------------------
    // Protocol checks

    assert property (@(posedge clk25) disable iff (!arstN)
        apbReq.penable |-> apbReq.psel)
        else $error("apbMaster: penable high without psel");

    assert property (@(posedge clk25) disable iff (!arstN)
        apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable)
        else $error("apbMaster: setup phase not followed by access phase");

endmodule

`default_nettype wire

// ==== design/cpuCore.sv ====
`default_nettype none

module cpuCore
    import cpuPkg::*;
    import busPkg::*;
(
    input  wire logic   clk25,
    input  wire logic   arstN,
    output memReqT      memReq,
    input  wire memRspT memRsp,
    output flagsT       flags,
    output logic        instrDone,
    output logic        halted
);

    typedef enum logic [3:0] {
        sFetch, sModRm, sDispLo, sDispHi, sAddr, sMemLo, sMemHi,
        sExec, sWrLo, sWrHi, sHalt
    } coreStateT;

    // ---------------------------------------------------------------------
    // Sequencer state and instruction payload

    coreStateT   state;
    logic [15:0] ip;
    logic [7:0]  opcode;
    modRmT       modRm;
    logic [15:0] disp;
    logic [15:0] eaQ;       // Latched in sAddr
    logic [7:0]  memLo;
    logic [7:0]  memHi;
    logic [15:0] resultQ;   // For memory write-back

    logic        isWord;
    logic        dirToReg;
    logic        regForm;
    aluOpT       aluOp;
    regSelT      rdSelA;
    regSelT      rdSelB;
    regSelT      wrSel;
    logic        wrEn;
    logic [15:0] rdA;
    logic [15:0] rdB;
    logic [15:0] ea;
    logic [15:0] memOp;
    logic [15:0] rmOp;
    logic [15:0] aluA;
    logic [15:0] aluB;
    logic [15:0] aluRes;
    flagsT       aluFlags;

    assign isWord   = opcode[0];        // W bit
    assign dirToReg = opcode[1];        // D bit, reg is destination
    assign aluOp    = aluOpT'(opcode[5:3]);
    assign regForm  = (modRm.mod == 2'b11);

    // In sAddr both read ports fetch the base pair instead of the operands
    always_comb begin
        if (state == sAddr) begin
            rdSelA.index  = (modRm.rm == 3'd7 || modRm.rm[2:1] == 2'b00) ? idxBx : idxBp;
            rdSelA.isWord = 1'b1;
            rdSelB.index  = modRm.rm[0] ? idxDi : idxSi;
            rdSelB.isWord = 1'b1;
        end else begin
            rdSelA.index  = modRm.regIdx;
            rdSelA.isWord = isWord;
            rdSelB.index  = modRm.rm;
            rdSelB.isWord = isWord;
        end
    end

    // Operand routing
    assign memOp = isWord ? {memHi, memLo} : {8'h00, memLo};
    assign rmOp  = regForm ? rdB : memOp;
    assign aluA  = dirToReg ? rdA : rmOp;
    assign aluB  = dirToReg ? rmOp : rdA;
    assign wrSel = dirToReg ? rdSelA : rdSelB;
    assign wrEn  = (state == sExec) && (aluOp != aluCmp) && (dirToReg || regForm);

    regFile regs_i (
        .clk25  (clk25),
        .arstN  (arstN),
        .rdSelA (rdSelA),
        .rdSelB (rdSelB),
        .rdA    (rdA),
        .rdB    (rdB),
        .wrEn   (wrEn),
        .wrSel  (wrSel),
        .wrData (aluRes)
    );

    // BX/BP share port A, SI/DI share port B
    eaCalc ea_i (
        .modRm (modRm),
        .bx    (rdA),
        .bp    (rdA),
        .si    (rdB),
        .di    (rdB),
        .disp  (disp),
        .ea    (ea)
    );

    aluUnit alu_i (
        .op       (aluOp),
        .isWord   (isWord),
        .a        (aluA),
        .b        (aluB),
        .cfIn     (flags.cf),
        .result   (aluRes),
        .flagsOut (aluFlags)
    );

    // ---------------------------------------------------------------------
    // Byte request, held by state until done

    always_comb begin
        memReq.valid = !(state inside {sAddr, sExec, sHalt});
        memReq.write = state inside {sWrLo, sWrHi};
        memReq.wdata = 8'h00;
        if (state == sWrLo) memReq.wdata = resultQ[7:0];
        if (state == sWrHi) memReq.wdata = resultQ[15:8];
        case (state)
            sMemLo, sWrLo: memReq.addr = eaQ;
            sMemHi, sWrHi: memReq.addr = eaQ + 16'd1;     // Low byte first
            default:       memReq.addr = ip;              // Code stream
        endcase
    end

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            state     <= sFetch;
            ip        <= resetIp;
            flags     <= '0;
            instrDone <= 1'b0;
            halted    <= 1'b0;
        end else begin
            instrDone <= 1'b0;
            case (state)
                sFetch: if (memRsp.done) begin
                    ip <= ip + 16'd1;
                    if (memRsp.rdata == opHlt) begin
                        halted <= 1'b1;
                        state  <= sHalt;
                    end else if (memRsp.rdata[7:6] == 2'b00 && !memRsp.rdata[2]) begin
                        state <= sModRm;
                    end else begin
                        instrDone <= 1'b1;    // Anything else is a one byte no-op
                    end
                end
                sModRm: if (memRsp.done) begin
                    ip <= ip + 16'd1;
                    if (memRsp.rdata[7:6] == 2'b11) begin
                        state <= sExec;
                    end else if (memRsp.rdata[7:6] != 2'b00 || memRsp.rdata[2:0] == 3'd6) begin
                        state <= sDispLo;     // disp8, disp16 or direct
                    end else begin
                        state <= sAddr;
                    end
                end
                sDispLo: if (memRsp.done) begin
                    ip    <= ip + 16'd1;
                    state <= (modRm.mod == 2'b01) ? sAddr : sDispHi;
                end
                sDispHi: if (memRsp.done) begin
                    ip    <= ip + 16'd1;
                    state <= sAddr;
                end
                sAddr:  state <= sMemLo;
                sMemLo: if (memRsp.done) state <= isWord ? sMemHi : sExec;
                sMemHi: if (memRsp.done) state <= sExec;
                sExec: begin
                    flags <= aluFlags;
                    if (aluOp == aluCmp || dirToReg || regForm) begin
                        state     <= sFetch;   // Register write lands this edge
                        instrDone <= 1'b1;
                    end else begin
                        state <= sWrLo;
                    end
                end
                sWrLo: if (memRsp.done) begin
                    if (isWord) begin
                        state <= sWrHi;
                    end else begin
                        state     <= sFetch;
                        instrDone <= 1'b1;
                    end
                end
                sWrHi: if (memRsp.done) begin
                    state     <= sFetch;
                    instrDone <= 1'b1;
                end
                sHalt:   state <= sHalt;       // Only reset leaves
                default: state <= sFetch;
            endcase
        end
    end

    // Fetched bytes and the latched address
    always_ff @(posedge clk25) begin
        if (memRsp.done) begin
            case (state)
                sFetch: opcode <= memRsp.rdata;
                sModRm: begin
                    modRm <= modRmT'(memRsp.rdata);
                    disp  <= '0;                // mod 00 has no displacement
                end
                sDispLo: disp <= {{8{memRsp.rdata[7]}}, memRsp.rdata};  // disp16 high overwrites
                sDispHi: disp[15:8] <= memRsp.rdata;
                sMemLo:  memLo <= memRsp.rdata;
                sMemHi:  memHi <= memRsp.rdata;
                default: ;
            endcase
        end
        if (state == sAddr) eaQ <= ea;
        if (state == sExec) resultQ <= aluRes;
    end

    // ---------------------------------------------------------------------
    // Handshake and FSM checks

    assert property (@(posedge clk25) disable iff (!arstN)
        memReq.valid && !memRsp.done |=> $stable(memReq))
        else $error("cpuCore: memReq changed while waiting for done");

    assert property (@(posedge clk25) disable iff (!arstN)
        state inside {sFetch, sModRm, sDispLo, sDispHi, sAddr, sMemLo, sMemHi,
                      sExec, sWrLo, sWrHi, sHalt})
        else $error("cpuCore: illegal state");

endmodule

`default_nettype wire

// ==== design/cpu86Top.sv ====
`default_nettype none

module cpu86Top
    import cpuPkg::*;
    import busPkg::*;
(
    input  wire logic   clk25,
    input  wire logic   arstN,
    output apbReqT      apbReq,
    input  wire apbRspT apbRsp,
    output flagsT       flags,
    output logic        instrDone,
    output logic        halted
);

    memReqT memReq;     // Core to bus block
    memRspT memRsp;

    cpuCore core_i (
        .clk25     (clk25),
        .arstN     (arstN),
        .memReq    (memReq),
        .memRsp    (memRsp),
        .flags     (flags),
        .instrDone (instrDone),
        .halted    (halted)
    );

    apbMaster apb_i (
        .clk25  (clk25),
        .arstN  (arstN),
        .memReq (memReq),
        .memRsp (memRsp),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

endmodule

`default_nettype wire

// ==== test/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Code bytes from address 0, one instruction per line
localparam int progLen = 54;
localparam logic [7:0] progImage [progLen] = '{
    8'h03, 8'h1E, 8'h00, 8'h10,     // ADD BX,[1000h]
    8'h03, 8'h36, 8'h02, 8'h10,     // ADD SI,[1002h]
    8'h03, 8'h3E, 8'h04, 8'h10,     // ADD DI,[1004h]
    8'h03, 8'h2E, 8'h06, 8'h10,     // ADD BP,[1006h]
    8'h03, 8'h00,                   // ADD AX,[BX+SI]
    8'h09, 8'h01,                   // OR [BX+DI],AX
    8'h02, 8'h22,                   // ADD AH,[BP+SI]
    8'h2A, 8'h04,                   // SUB AL,[SI]
    8'h13, 8'h56, 8'hFE,            // ADC DX,[BP-2]
    8'h31, 8'h05,                   // XOR [DI],AX
    8'h1B, 8'h8F, 8'h23, 8'h01,     // SBB CX,[BX+0123h]
    8'h1B, 8'h13,                   // SBB DX,[BP+DI]
    8'h23, 8'hC8,                   // AND CX,AX
    8'h39, 8'h40, 8'h10,            // CMP [BX+SI+10h],AX
    8'h02, 8'h7D, 8'h08,            // ADD BH,[DI+8]
    8'h00, 8'hE3,                   // ADD BL,AH
    8'h09, 8'h1E, 8'h10, 8'h10,     // OR [1010h],BX
    8'h00, 8'h06, 8'h12, 8'h10,     // ADD [1012h],AL
    8'hF4                           // HLT
};

// Data reads in bus order, {address, initial byte}
localparam int numReads = 28;
localparam logic [23:0] dataReads [numReads] = '{
    24'h1000_00, 24'h1001_20, 24'h1002_00, 24'h1003_04, 24'h1004_00, 24'h1005_06,
    24'h1006_00, 24'h1007_30, 24'h2400_34, 24'h2401_12, 24'h2600_00, 24'h2601_00,
    24'h3400_80, 24'h0400_35, 24'h2FFE_FF, 24'h2FFF_FF, 24'h0600_0F, 24'h0601_F0,
    24'h2123_01, 24'h2124_00, 24'h3600_00, 24'h3601_80, 24'h2410_00, 24'h2411_70,
    24'h0608_11, 24'h1010_00, 24'h1011_00, 24'h1012_80
};

// Bus writes in order, {address, byte}
localparam int numWrites = 7;
localparam logic [23:0] expWrites [numWrites] = '{
    24'h2600_34, 24'h2601_12, 24'h0600_F0, 24'h0601_62,
    24'h1010_92, 24'h1011_31, 24'h1012_7F
};

// Flags at each instrDone, {cf, zf, sf, of}
localparam int numFlags = 18;
localparam logic [3:0] expFlags [numFlags] = '{
    4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b0000,
    4'b0010, 4'b1010, 4'b1100, 4'b0000, 4'b1010, 4'b1000,
    4'b0010, 4'b1011, 4'b0000, 4'b0010, 4'b0000, 4'b1001
};

`endif

// ==== test/cpu86Tb.sv ====
`default_nettype none

module cpu86Tb
    import cpuPkg::*;
    import busPkg::*;
();

    `include "tbProgram.svh"

    localparam int          watchdogCycles = progLen * 40;
    localparam logic [15:0] codeTop        = 16'h0100;     // Reads below this are fetches

    logic        clk25;
    logic        arstN;
    apbReqT      apbReq;
    apbRspT      apbRsp;
    flagsT       flags;
    logic        instrDone;
    logic        halted;

    logic [7:0]  mem [65536];      // 64 KB behind the APB port
    integer      seed = 32'h9b0b_6f78;
    logic [31:0] rnd;
    logic [1:0]  waitLeft;         // Wait states left in this access

    int busErrs  = 0;
    int memErrs  = 0;
    int flagErrs = 0;
    int endErrs  = 0;
    int wrIdx    = 0;
    int rdIdx    = 0;
    int codeIdx  = 0;
    int flagIdx  = 0;

    cpu86Top dut_i (
        .clk25     (clk25),
        .arstN     (arstN),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .flags     (flags),
        .instrDone (instrDone),
        .halted    (halted)
    );

    initial clk25 = 1'b0;
    always #5 clk25 = ~clk25;

    function automatic logic [7:0] fillByte(logic [15:0] addr);
        return addr[15:8] ^ addr[7:0] ^ 8'h5A;     // Both address bytes matter
    endfunction

    task automatic loadMemory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = fillByte(16'(i));
        end
        for (int i = 0; i < progLen; i++) begin
            mem[i] = progImage[i];
        end
        for (int i = 0; i < numReads; i++) begin
            mem[dataReads[i][23:8]] = dataReads[i][7:0];
        end
    endtask

    task automatic printCounts();
        $display("Errors: protocol %0d, memory %0d, flags %0d, completion %0d",
                 busErrs, memErrs, flagErrs, endErrs);
    endtask

    // ------------------------------------------------------------------
    // APB memory, random wait states in the access phase

    always @(posedge clk25) begin
        #1;
        if (apbReq.psel && !apbReq.penable) begin
            rnd           = $random(seed);
            waitLeft      = rnd[1:0];
            apbRsp.pready = 1'b0;
        end else if (apbReq.psel && apbReq.penable) begin
            if (waitLeft == 2'd0) begin
                apbRsp.pready = 1'b1;
                apbRsp.prdata = mem[apbReq.paddr];
                if (apbReq.pwrite) begin
                    mem[apbReq.paddr] = apbReq.pwdata;
                end
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end else begin
            apbRsp.pready = 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // Transfer and flag checks

    always @(posedge clk25) begin
        if (arstN && apbReq.psel && apbReq.penable && apbRsp.pready) begin
            if (apbReq.pwrite) begin
                assert (wrIdx < numWrites && {apbReq.paddr, apbReq.pwdata} == expWrites[wrIdx])
                else begin
                    $display("[FAIL] %0t: write %0d is %h <- %h, expected %h", $time, wrIdx,
                             apbReq.paddr, apbReq.pwdata, expWrites[wrIdx]);
                    memErrs++;
                end
                wrIdx++;
            end else if (apbReq.paddr < codeTop) begin
                assert (apbReq.paddr == 16'(codeIdx)) else begin
                    $display("[FAIL] %0t: fetch from %h, expected %h", $time,
                             apbReq.paddr, 16'(codeIdx));
                    memErrs++;
                end
                codeIdx++;
            end else begin
                assert (rdIdx < numReads && apbReq.paddr == dataReads[rdIdx][23:8]) else begin
                    $display("[FAIL] %0t: data read %0d from %h, expected %h", $time, rdIdx,
                             apbReq.paddr, dataReads[rdIdx][23:8]);
                    memErrs++;
                end
                rdIdx++;
            end
        end
        if (arstN && instrDone) begin
            assert (flagIdx < numFlags && flags == expFlags[flagIdx]) else begin
                $display("[FAIL] %0t: flags %b after instruction %0d, expected %b", $time,
                         flags, flagIdx, expFlags[flagIdx]);
                flagErrs++;
            end
            flagIdx++;
        end
    end

    // Idle bus and cleared outputs in and right after reset
    assert property (@(posedge clk25) (!arstN || $rose(arstN)) |->
        !apbReq.psel && !apbReq.penable && flags == '0 && !instrDone && !halted)
        else begin
            $display("[FAIL] %0t: outputs active during reset", $time);
            busErrs++;
        end

    assert property (@(posedge clk25) disable iff (!arstN)
        $rose(apbReq.penable) |-> $past(apbReq.psel && !apbReq.penable))
        else begin
            $display("[FAIL] %0t: access phase without setup phase", $time);
            busErrs++;
        end

    assert property (@(posedge clk25) disable iff (!arstN)
        apbReq.penable |-> apbReq.psel)
        else begin
            $display("[FAIL] %0t: penable high with psel low", $time);
            busErrs++;
        end

    // Hold everything until pready ends the access
    assert property (@(posedge clk25) disable iff (!arstN)
        apbReq.psel && !(apbReq.penable && apbRsp.pready) |=>
            apbReq.psel && $stable(apbReq.paddr) && $stable(apbReq.pwrite)
            && $stable(apbReq.pwdata))
        else begin
            $display("[FAIL] %0t: transfer dropped or changed before pready", $time);
            busErrs++;
        end

    assert property (@(posedge clk25) disable iff (!arstN)
        halted |-> !apbReq.psel ##1 halted)
        else begin
            $display("[FAIL] %0t: bus activity or halt lost after HLT", $time);
            busErrs++;
        end

    task automatic checkTotals();
        assert (wrIdx == numWrites) else begin
            $display("[FAIL] %0t: %0d writes, expected %0d", $time, wrIdx, numWrites);
            endErrs++;
        end
        assert (rdIdx == numReads) else begin
            $display("[FAIL] %0t: %0d data reads, expected %0d", $time, rdIdx, numReads);
            endErrs++;
        end
        assert (codeIdx == progLen) else begin
            $display("[FAIL] %0t: %0d fetches, expected %0d", $time, codeIdx, progLen);
            endErrs++;
        end
        assert (flagIdx == numFlags) else begin
            $display("[FAIL] %0t: %0d instrDone pulses, expected %0d", $time,
                     flagIdx, numFlags);
            endErrs++;
        end
    endtask

    // ------------------------------------------------------------------
    // Reset, run to HLT, summary

    initial begin
        arstN  = 1'b1;
        apbRsp = '0;
        loadMemory();
        #1 arstN = 1'b0;
        repeat (5) @(posedge clk25);
        #1 arstN = 1'b1;
        while (!halted) begin
            @(posedge clk25);
        end
        repeat (20) @(posedge clk25);   // Bus must stay quiet after HLT
        checkTotals();
        printCounts();
        if (busErrs + memErrs + flagErrs + endErrs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk25);
        $display("Timeout: the core did not halt within %0d cycles", watchdogCycles);
        printCounts();
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu86Core.f ====
+incdir+test
design/cpuPkg.sv
design/busPkg.sv
design/regFile.sv
design/eaCalc.sv
design/aluUnit.sv
design/apbMaster.sv
design/cpuCore.sv
design/cpu86Top.sv
test/cpu86Tb.sv
